// File: logic/mf2_pkg.sv
`default_nettype none

package mf2_pkg;

	////////////////////////////////
	// Bus widths and types

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;
	localparam int SHADOW_DEPTH = 8192; // 8 KB cartridge RAM

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] byte_t;
	typedef logic [$clog2(SHADOW_DEPTH)-1:0] shadow_addr_t;

	typedef enum logic [1:0] {
		MODE_ENABLED  = 2'd0,
		MODE_HIDDEN   = 2'd1,
		MODE_DISABLED = 2'd2
	} mf2_mode_t;

	////////////////////////////////
	// CPU addresses

	localparam addr_t NMI_VECTOR  = 16'h0066;
	localparam addr_t HIDE_VECTOR = 16'h0065; // Self-hide fetch

	// FEE8 enables, FEEA disables
	localparam addr_t PORT_MF2_CTRL = 16'hFEE8;
	localparam logic [ADDR_W-3:0] PORT_MF2_CTRL_HI = PORT_MF2_CTRL[ADDR_W-1:2];

	// Snooped port high bytes
	localparam byte_t PORT_GA        = 8'h7F;
	localparam byte_t PORT_CRTC_SEL  = 8'hBC;
	localparam byte_t PORT_CRTC_DATA = 8'hBD;
	localparam byte_t PORT_PPI       = 8'hF7; // 8255
	localparam byte_t PORT_ROM_SEL   = 8'hDF; // Upper ROM select

	////////////////////////////////
	// Shadow RAM slots

	localparam shadow_addr_t SLOT_PEN_INDEX = 13'h1FCF;
	localparam shadow_addr_t SLOT_PEN_BASE  = 13'h1F90; // Plus pen 0..15
	localparam shadow_addr_t SLOT_BORDER    = 13'h1FDF;
	localparam shadow_addr_t SLOT_MODE      = 13'h1FEF;
	localparam shadow_addr_t SLOT_BANK      = 13'h1FFF;
	localparam shadow_addr_t SLOT_CRTC_SEL  = 13'h1CFF;
	localparam shadow_addr_t SLOT_CRTC_BASE = 13'h1DB0; // Plus register 0..15
	localparam shadow_addr_t SLOT_PPI       = 13'h17FF;
	localparam shadow_addr_t SLOT_ROM_SEL   = 13'h1AAC;

	// Address bits 15:13 of the cartridge windows
	localparam logic [2:0] ROM_WINDOW = 3'b000;
	localparam logic [2:0] RAM_WINDOW = 3'b001;

endpackage

`default_nettype wire

// File: logic/mf2_port_snoop.sv
`timescale 1ns/1ps
`default_nettype none

module mf2_port_snoop import mf2_pkg::*; (
	input  wire          clk_sys,
	input  wire          reset,
	input  wire addr_t   cpu_addr,
	input  wire byte_t   cpu_dout,
	input  wire          io_wr,
	output logic         io_wr_rise,
	output logic         store_req,
	output shadow_addr_t store_addr,
	output byte_t        store_data
);

	logic         io_wr_q;
	logic         wr_edge;
	logic [4:0]   pen_index; // Bit 4 selects the border
	logic [3:0]   crtc_reg;
	logic         slot_hit;
	shadow_addr_t slot_addr;
	logic         ga_pen_sel;

	assign wr_edge = io_wr & ~io_wr_q;

	// Gate array function is in the top two data bits
	assign ga_pen_sel = (cpu_addr[15:8] == PORT_GA) && (cpu_dout[7:6] == 2'b00);

	////////////////////////////////
	// Slot table

	always_comb begin
		slot_hit = 1'b1;
		slot_addr = '0;
		case (cpu_addr[15:8])
			PORT_GA: begin
				case (cpu_dout[7:6])
					2'b00: slot_addr = SLOT_PEN_INDEX;
					2'b01: begin // Pen color
						if (pen_index[4])
							slot_addr = SLOT_BORDER;
						else
							slot_addr = SLOT_PEN_BASE + shadow_addr_t'(pen_index[3:0]);
					end
					2'b10: slot_addr = SLOT_MODE;   // Screen mode and ROM enables
					default: slot_addr = SLOT_BANK; // RAM banking
				endcase
			end
			PORT_CRTC_SEL:  slot_addr = SLOT_CRTC_SEL;
			PORT_CRTC_DATA: slot_addr = SLOT_CRTC_BASE + shadow_addr_t'(crtc_reg);
			PORT_PPI:       slot_addr = SLOT_PPI;
			PORT_ROM_SEL:   slot_addr = SLOT_ROM_SEL;
			default:        slot_hit = 1'b0;
		endcase
	end

	////////////////////////////////
	// Edge and index tracking

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
			io_wr_rise <= 1'b0;
			store_req <= 1'b0;
			pen_index <= '0;
			crtc_reg <= '0;
		end else begin
			io_wr_q <= io_wr;
			io_wr_rise <= wr_edge;
			store_req <= wr_edge & slot_hit;

			if (wr_edge && ga_pen_sel)
				pen_index <= cpu_dout[4:0];
			if (wr_edge && cpu_addr[15:8] == PORT_CRTC_SEL)
				crtc_reg <= cpu_dout[3:0];
		end
	end

	// Slot and byte, taken with the edge
	always_ff @(posedge clk_sys) begin
		if (wr_edge) begin
			store_addr <= slot_addr; // Uses the index from before this write
			store_data <= cpu_dout;
		end
	end

endmodule

`default_nettype wire

// File: logic/mf2_control.sv
`timescale 1ns/1ps
`default_nettype none

module mf2_control import mf2_pkg::*; (
	input  wire            clk_sys,
	input  wire            reset,
	input  wire mf2_mode_t mode,
	input  wire addr_t     cpu_addr,
	input  wire            m1,
	input  wire            key_nmi,
	input  wire            io_wr_rise,
	output logic           nmi,
	output logic           mf2_en,
	output logic           hidden
);

	logic key_q;
	logic m1_q;
	logic key_rise;
	logic m1_rise;
	logic ctrl_port;
	logic nmi_fetch;
	logic hide_fetch;

	assign key_rise = key_nmi & ~key_q;
	assign m1_rise = m1 & ~m1_q;

	// FEE8 or FEEA, bit 0 ignored
	assign ctrl_port = (cpu_addr[15:2] == PORT_MF2_CTRL_HI);

	assign nmi_fetch = m1_rise & nmi & (cpu_addr == NMI_VECTOR);
	assign hide_fetch = m1_rise & mf2_en & (cpu_addr == HIDE_VECTOR);

	////////////////////////////////
	// Cartridge state

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			key_q <= 1'b0;
			m1_q <= 1'b0;
			nmi <= 1'b0;
			mf2_en <= 1'b0;
			hidden <= (mode != MODE_ENABLED); // Hidden or disabled
		end else begin
			key_q <= key_nmi;
			m1_q <= m1;

			// Freeze key
			if (key_rise && !mf2_en && mode != MODE_DISABLED)
				nmi <= 1'b1;

			// CPU takes the NMI, page the cartridge in
			if (nmi_fetch) begin
				mf2_en <= 1'b1;
				hidden <= 1'b0;
				nmi <= 1'b0;
			end

			if (hide_fetch)
				hidden <= 1'b1;

			// Port write overrides the fetch paths
			if (io_wr_rise && ctrl_port)
				mf2_en <= ~cpu_addr[1] & ~hidden; // A hidden cartridge stays out
		end
	end

endmodule

`default_nettype wire

// File: logic/mf2_shadow_ram.sv
`timescale 1ns/1ps
`default_nettype none

module mf2_shadow_ram import mf2_pkg::*; (
	input  wire               clk_sys,
	input  wire addr_t        cpu_addr,
	input  wire byte_t        cpu_dout,
	input  wire               mem_rd,
	input  wire               mem_wr,
	input  wire               mf2_en,
	input  wire               store_req,
	input  wire shadow_addr_t store_addr,
	input  wire byte_t        store_data,
	output logic              ram_en,
	output byte_t             dout
);

	byte_t        mem [SHADOW_DEPTH];
	shadow_addr_t port_addr;
	logic         port_we;
	byte_t        port_data;
	byte_t        ram_out;

	assign ram_en = mf2_en & (cpu_addr[15:13] == RAM_WINDOW);

	////////////////////////////////
	// Port select

	always_ff @(posedge clk_sys) begin
		if (store_req) begin // Snoop beats the CPU
			port_addr <= store_addr;
			port_data <= store_data;
			port_we <= 1'b1;
		end else if (mem_wr && ram_en) begin
			port_addr <= cpu_addr[12:0];
			port_data <= cpu_dout;
			port_we <= 1'b1;
		end else begin
			port_addr <= cpu_addr[12:0]; // Plain read
			port_we <= 1'b0;
		end
	end

	////////////////////////////////
	// Array

	always_ff @(posedge clk_sys) begin
		if (port_we) begin
			mem[port_addr] <= port_data;
			ram_out <= port_data; // Written byte shows up on the read side
		end else begin
			ram_out <= mem[port_addr];
		end
	end

	// Open bus outside the window
	assign dout = (mem_rd && ram_en) ? ram_out : 8'hFF;

endmodule

`default_nettype wire

// File: logic/multiface2.sv
`timescale 1ns/1ps
`default_nettype none

module multiface2 import mf2_pkg::*; (
	input  wire            clk_sys,
	input  wire            reset,
	input  wire mf2_mode_t mode,
	input  wire addr_t     cpu_addr,
	input  wire byte_t     cpu_dout,
	input  wire            mem_rd,
	input  wire            mem_wr,
	input  wire            io_wr,
	input  wire            m1,
	input  wire            key_nmi,
	output logic           nmi,
	output logic           mf2_en,
	output logic           rom_en,
	output logic           ram_en,
	output byte_t          dout
);

	logic         io_wr_rise;
	logic         store_req;
	shadow_addr_t store_addr;
	byte_t        store_data;
	logic         hidden; // Observed by the property checks only

	// Cartridge ROM lives outside this block
	assign rom_en = mf2_en & (cpu_addr[15:13] == ROM_WINDOW);

	////////////////////////////////
	// Hardware register snoop

	mf2_port_snoop u_snoop (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_addr   (cpu_addr),
		.cpu_dout   (cpu_dout),
		.io_wr      (io_wr),
		.io_wr_rise (io_wr_rise),
		.store_req  (store_req),
		.store_addr (store_addr),
		.store_data (store_data)
	);

	////////////////////////////////
	// NMI and paging

	mf2_control u_control (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.mode       (mode),
		.cpu_addr   (cpu_addr),
		.m1         (m1),
		.key_nmi    (key_nmi),
		.io_wr_rise (io_wr_rise),
		.nmi        (nmi),
		.mf2_en     (mf2_en),
		.hidden     (hidden)
	);

	////////////////////////////////
	// 8 KB RAM at 0x2000

	mf2_shadow_ram u_ram (
		.clk_sys    (clk_sys),
		.cpu_addr   (cpu_addr),
		.cpu_dout   (cpu_dout),
		.mem_rd     (mem_rd),
		.mem_wr     (mem_wr),
		.mf2_en     (mf2_en),
		.store_req  (store_req),
		.store_addr (store_addr),
		.store_data (store_data),
		.ram_en     (ram_en),
		.dout       (dout)
	);

endmodule

`default_nettype wire

// File: bench/multiface2_props.sv
`timescale 1ns/1ps
`default_nettype none

module multiface2_props import mf2_pkg::*; (
	input wire            clk_sys,
	input wire            reset,
	input wire mf2_mode_t mode,
	input wire addr_t     cpu_addr,
	input wire            mem_rd,
	input wire            m1,
	input wire            key_nmi,
	input wire            nmi,
	input wire            mf2_en,
	input wire            hidden,
	input wire byte_t     dout
);

	int fail_count = 0; // Read by the testbench at the end

	////////////////////////////////
	// NMI request

	// Freeze key edge gives nmi on the next cycle
	nmi_latency: assert property (@(posedge clk_sys) disable iff (reset)
		($rose(key_nmi) && !mf2_en && mode != MODE_DISABLED) |=> nmi)
		else begin
			fail_count++;
			$error("nmi did not rise one cycle after the freeze key");
		end

	nmi_blocked: assert property (@(posedge clk_sys) disable iff (reset)
		(mode == MODE_DISABLED) |-> !nmi)
		else begin
			fail_count++;
			$error("nmi is high while the cartridge mode is disabled");
		end

	////////////////////////////////
	// Paging and bus

	hidden_at_reset: assert property (@(posedge clk_sys)
		$fell(reset) |-> (hidden == (mode != MODE_ENABLED)))
		else begin
			fail_count++;
			$error("hidden does not match the mode after reset");
		end

	hide_fetch: assert property (@(posedge clk_sys) disable iff (reset)
		($rose(m1) && mf2_en && cpu_addr == HIDE_VECTOR) |=> hidden)
		else begin
			fail_count++;
			$error("fetch at 0x0065 did not hide the cartridge");
		end

	// Window taken from the address map, not from the DUT decode
	open_bus: assert property (@(posedge clk_sys)
		!(mem_rd && mf2_en && cpu_addr[15:13] == RAM_WINDOW) |-> (dout == 8'hFF))
		else begin
			fail_count++;
			$error("dout is not 0xFF outside a RAM window read");
		end

endmodule

bind multiface2 multiface2_props u_props (
	.clk_sys  (clk_sys),
	.reset    (reset),
	.mode     (mode),
	.cpu_addr (cpu_addr),
	.mem_rd   (mem_rd),
	.m1       (m1),
	.key_nmi  (key_nmi),
	.nmi      (nmi),
	.mf2_en   (mf2_en),
	.hidden   (hidden),
	.dout     (dout)
);

`default_nettype wire

// File: bench/multiface2_tb.sv
`timescale 1ns/1ps
`default_nettype none

module multiface2_tb import mf2_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 4000; // About twice the test length
	localparam int RAM_PAIRS = 48;
	localparam int SNOOP_ROUNDS = 8;

	logic      clk_sys;
	logic      reset;
	mf2_mode_t mode;
	addr_t     cpu_addr;
	byte_t     cpu_dout;
	logic      mem_rd;
	logic      mem_wr;
	logic      io_wr;
	logic      m1;
	logic      key_nmi;
	logic      nmi;
	logic      mf2_en;
	logic      rom_en;
	logic      ram_en;
	byte_t     dout;

	byte_t        exp_mem [SHADOW_DEPTH]; // Expected shadow contents
	shadow_addr_t touched [$];
	logic [31:0]  lcg_state;
	logic [4:0]   exp_pen;
	logic [3:0]   exp_crtc;
	int           errors;
	int           checks;
	int           cycle_count;

	multiface2 DUT (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.mode     (mode),
		.cpu_addr (cpu_addr),
		.cpu_dout (cpu_dout),
		.mem_rd   (mem_rd),
		.mem_wr   (mem_wr),
		.io_wr    (io_wr),
		.m1       (m1),
		.key_nmi  (key_nmi),
		.nmi      (nmi),
		.mf2_en   (mf2_en),
		.rom_en   (rom_en),
		.ram_en   (ram_en),
		.dout     (dout)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic byte_t rand_byte();
		return byte_t'(lcg_next() >> 16);
	endfunction

	////////////////////////////////
	// Bus cycles

	task automatic strobe_hold(); // Held three cycles before release
		repeat (3) @(posedge clk_sys);
		#5;
	endtask

	task automatic apply_reset(input mf2_mode_t m);
		@(posedge clk_sys);
		#5;
		reset = 1'b1;
		mode = m;
		repeat (4) @(posedge clk_sys);
		#5;
		reset = 1'b0;
	endtask

	task automatic io_write(input addr_t a, input byte_t d);
		@(posedge clk_sys);
		#5;
		cpu_addr = a;
		cpu_dout = d;
		io_wr = 1'b1;
		strobe_hold();
		io_wr = 1'b0;
	endtask

	task automatic mem_write(input addr_t a, input byte_t d);
		@(posedge clk_sys);
		#5;
		cpu_addr = a;
		cpu_dout = d;
		mem_wr = 1'b1;
		strobe_hold();
		mem_wr = 1'b0;
		exp_mem[a[12:0]] = d;
		touched.push_back(a[12:0]);
	endtask

	task automatic mem_read(input addr_t a, output byte_t d);
		@(posedge clk_sys);
		#5;
		cpu_addr = a;
		mem_rd = 1'b1;
		repeat (2) @(posedge clk_sys);
		#5;
		d = dout; // Two cycles after the address
		@(posedge clk_sys);
		#5;
		mem_rd = 1'b0;
	endtask

	task automatic m1_fetch(input addr_t a);
		@(posedge clk_sys);
		#5;
		cpu_addr = a;
		m1 = 1'b1;
		strobe_hold();
		m1 = 1'b0;
	endtask

	task automatic key_press();
		@(posedge clk_sys);
		#5;
		key_nmi = 1'b1;
		strobe_hold();
		key_nmi = 1'b0;
	endtask

	////////////////////////////////
	// Checks and model

	task automatic check_byte(input string what, input byte_t got, input byte_t want);
		checks++;
		assert (got === want) else begin
			$display("Error at time %0t: %s gave 0x%02h, expected 0x%02h", $time, what, got, want);
			errors++;
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic want);
		checks++;
		assert (got === want) else begin
			$display("Error at time %0t: %s is %b, expected %b", $time, what, got, want);
			errors++;
		end
	endtask

	// Register write seen by the snoop and its expected slot
	task automatic snoop_write(input addr_t port, input byte_t d);
		shadow_addr_t slot;
		slot = SLOT_ROM_SEL;
		case (port[15:8])
			PORT_GA: begin
				if (d[7:6] == 2'b00)
					slot = SLOT_PEN_INDEX;
				else if (d[7:6] == 2'b01)
					slot = exp_pen[4] ? SLOT_BORDER : SLOT_PEN_BASE + 13'(exp_pen[3:0]);
				else if (d[7:6] == 2'b10)
					slot = SLOT_MODE;
				else
					slot = SLOT_BANK;
				if (d[7:6] == 2'b00)
					exp_pen = d[4:0];
			end
			PORT_CRTC_SEL: begin
				slot = SLOT_CRTC_SEL;
				exp_crtc = d[3:0];
			end
			PORT_CRTC_DATA: slot = SLOT_CRTC_BASE + 13'(exp_crtc);
			PORT_PPI:       slot = SLOT_PPI;
			default:        slot = SLOT_ROM_SEL;
		endcase
		io_write(port, d);
		exp_mem[slot] = d;
		touched.push_back(slot);
	endtask

	task automatic verify_shadow();
		byte_t got;
		foreach (touched[i]) begin
			mem_read({RAM_WINDOW, touched[i]}, got);
			check_byte($sformatf("shadow offset 0x%04h", touched[i]), got, exp_mem[touched[i]]);
		end
		touched.delete();
	endtask

	initial begin
		byte_t got;
		byte_t d;
		addr_t a;
		addr_t edges [6];
		lcg_state = 32'h7932_45b0;
		errors = 0;
		checks = 0;
		reset = 1'b1;
		mode = MODE_ENABLED;
		cpu_addr = '0;
		cpu_dout = '0;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		io_wr = 1'b0;
		m1 = 1'b0;
		key_nmi = 1'b0;
		exp_pen = '0;
		exp_crtc = '0;
		edges = '{16'h0000, 16'h1FFF, 16'h2000, 16'h3FFF, 16'h4000, 16'hFFFF};

		// Reset state
		apply_reset(MODE_ENABLED);
		cpu_addr = 16'h2000;
		#1;
		check_bit("nmi after reset", nmi, 1'b0);
		check_bit("mf2_en after reset", mf2_en, 1'b0);
		check_bit("rom_en after reset", rom_en, 1'b0);
		check_bit("ram_en after reset", ram_en, 1'b0);
		check_byte("dout after reset", dout, 8'hFF);

		// Freeze and page in
		key_press();
		check_bit("nmi after freeze key", nmi, 1'b1);
		m1_fetch(NMI_VECTOR);
		check_bit("mf2_en after NMI fetch", mf2_en, 1'b1);
		check_bit("nmi after NMI fetch", nmi, 1'b0);
		for (int i = 0; i < 14; i++) begin
			a = (i < 6) ? edges[i] : addr_t'(lcg_next() >> 16);
			@(posedge clk_sys);
			#5;
			cpu_addr = a;
			#1;
			check_bit($sformatf("rom_en at 0x%04h", a), rom_en, a < 16'h2000);
			check_bit($sformatf("ram_en at 0x%04h", a), ram_en, a >= 16'h2000 && a < 16'h4000);
		end

		////////////////////////////////
		// Shadow RAM through the window
		for (int i = 0; i < RAM_PAIRS; i++) begin
			a = {RAM_WINDOW, 13'(lcg_next() >> 12)};
			d = rand_byte();
			mem_write(a, d);
			mem_read(a, got);
			check_byte($sformatf("readback at 0x%04h", a), got, d);
		end
		verify_shadow();
		for (int i = 0; i < 16; i++) begin
			a = addr_t'(lcg_next() >> 16);
			if (a[15:13] == RAM_WINDOW)
				a[15] = 1'b1;
			mem_read(a, got);
			check_byte($sformatf("read outside window at 0x%04h", a), got, 8'hFF);
		end

		// Register snoop with the pen select on the border every other round
		for (int r = 0; r < SNOOP_ROUNDS; r++) begin
			d = (rand_byte() & 8'h2F) | ((r % 2 == 1) ? 8'h10 : 8'h00);
			snoop_write(16'h7F00, d);
			snoop_write(16'h7F00, 8'h40 | (rand_byte() & 8'h3F));
			snoop_write(16'h7F00, 8'h80 | (rand_byte() & 8'h3F));
			snoop_write(16'h7F00, 8'hC0 | rand_byte());
			snoop_write(16'hBC00, rand_byte() & 8'h0F);
			snoop_write(16'hBD00, rand_byte());
			snoop_write(16'hF700, rand_byte());
			snoop_write(16'hDF00, rand_byte());
		end
		verify_shadow();

		// Control ports and self-hide
		io_write(16'hFEEA, rand_byte());
		check_bit("mf2_en after FEEA", mf2_en, 1'b0);
		io_write(16'hFEE8, rand_byte());
		check_bit("mf2_en after FEE8", mf2_en, 1'b1);
		m1_fetch(HIDE_VECTOR);
		io_write(16'hFEE8, rand_byte());
		check_bit("mf2_en after hide and FEE8", mf2_en, 1'b0);

		// Disabled cartridge ignores the key
		apply_reset(MODE_DISABLED);
		key_press();
		check_bit("nmi with mode disabled", nmi, 1'b0);
		m1_fetch(NMI_VECTOR);
		check_bit("mf2_en with mode disabled", mf2_en, 1'b0);

		$display("Checks run: %0d, data errors: %0d, assertion failures: %0d",
			checks, errors, DUT.u_props.fail_count);
		if (errors == 0 && DUT.u_props.fail_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: multiface2.f
logic/mf2_pkg.sv
logic/mf2_port_snoop.sv
logic/mf2_control.sv
logic/mf2_shadow_ram.sv
logic/multiface2.sv
bench/multiface2_props.sv
bench/multiface2_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the multiface2 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	--top-module multiface2_tb -f multiface2.f -o Vmultiface2_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vmultiface2_tb +verilator+error+limit+1000 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "ALL TESTS PASSED" <<< "$output"; then
	echo "Simulation result: pass"
	exit 0
else
	echo "Simulation result: fail"
	exit 1
fi
